// File: hw/scan_settings.svh
// ----------------------------------------------------------
// Stream scanner sizes
// Pattern count, string and window depth, bus and counter widths
// ----------------------------------------------------------
`ifndef SCAN_SETTINGS_SVH
`define SCAN_SETTINGS_SVH

// One comparator per flagged string
`define SCAN_NUM_PATTERNS 4

// Longest flagged string in bytes
`define SCAN_PATTERN_BYTES 17

// Five stream words of history
`define SCAN_WINDOW_BYTES 20

`define SCAN_ADR_WIDTH 6
`define SCAN_COUNT_WIDTH 16

`endif

// File: hw/scan_pkg.sv
// ----------------------------------------------------------
// Stream scanner types
// Wishbone, stream and pattern structs plus register decode
// ----------------------------------------------------------
`include "scan_settings.svh"

package scan_pkg;

  typedef struct packed {
    logic                       cyc;
    logic                       stb;
    logic                       we;
    logic [`SCAN_ADR_WIDTH-1:0] adr;
    logic [31:0]                dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Low byte of data is the earliest stream byte
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } stream_t;

  // Right aligned, index 16 is the last character
  typedef struct packed {
    logic [`SCAN_PATTERN_BYTES-1:0][7:0] chars;
    logic [4:0]                          len;
  } pattern_t;

  typedef enum logic [2:0] {
    pattern_chars,
    pattern_len,
    control,
    status_hits,
    status_count,
    unmapped
  } reg_sel_e;

endpackage

// File: hw/pattern_regs.sv
// ----------------------------------------------------------
// Scanner register block
// Wishbone classic slave holding the flagged strings,
// the clear control and the status readback
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "scan_settings.svh"

module pattern_regs (
  input  logic                          clk,
  input  logic                          n_rst,
  input  scan_pkg::wb_req_t             wb_req,
  output scan_pkg::wb_rsp_t             wb_rsp,
  output scan_pkg::pattern_t            patterns [`SCAN_NUM_PATTERNS],
  output logic                          clear,
  input  logic [`SCAN_NUM_PATTERNS-1:0] hits,
  input  logic [`SCAN_COUNT_WIDTH-1:0]  hit_count
);

  logic [`SCAN_PATTERN_BYTES-1:0][7:0] chars_q [`SCAN_NUM_PATTERNS];
  logic [4:0]                          len_q [`SCAN_NUM_PATTERNS];
  scan_pkg::reg_sel_e                  sel;
  logic [1:0]                          pat_idx;
  logic [2:0]                          word_idx;
  logic                                req_fire;
  logic                                wr_en;
  logic                                ack_q;
  logic [31:0]                         rd_data;
  logic [31:0]                         rd_data_q;

  // Pattern p lives at 8p, characters at offsets 0..4, length at 5
  always_comb begin
    pat_idx  = wb_req.adr[4:3];
    word_idx = wb_req.adr[2:0];
    sel      = scan_pkg::unmapped;
    if (!wb_req.adr[`SCAN_ADR_WIDTH-1]) begin
      if (word_idx <= 3'd4) begin
        sel = scan_pkg::pattern_chars;
      end else if (word_idx == 3'd5) begin
        sel = scan_pkg::pattern_len;
      end
    end else begin
      case (wb_req.adr[4:0])
        5'd0:    sel = scan_pkg::control;
        5'd1:    sel = scan_pkg::status_hits;
        5'd2:    sel = scan_pkg::status_count;
        default: sel = scan_pkg::unmapped;
      endcase
    end
  end

  // Single cycle ack, no wait states
  assign req_fire = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_en    = req_fire && wb_req.we;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      ack_q <= 1'b0;
      clear <= 1'b0;
    end else begin
      ack_q <= req_fire;
      clear <= wr_en && (sel == scan_pkg::control) && wb_req.dat[0];
    end
  end

  // Character word k carries bytes 4k..4k+3
  always_ff @(posedge clk) begin
    if (wr_en && sel == scan_pkg::pattern_chars) begin
      for (int i = 0; i < `SCAN_PATTERN_BYTES; i++) begin
        if (i / 4 == word_idx) begin
          chars_q[pat_idx][i] <= wb_req.dat[8*(i%4) +: 8];
        end
      end
    end
  end

  // Zero length keeps a comparator idle after reset
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      for (int p = 0; p < `SCAN_NUM_PATTERNS; p++) begin
        len_q[p] <= '0;
      end
    end else if (wr_en && sel == scan_pkg::pattern_len) begin
      len_q[pat_idx] <= wb_req.dat[4:0];
    end
  end

  always_comb begin
    rd_data = '0;
    case (sel)
      scan_pkg::pattern_chars: begin
        for (int i = 0; i < `SCAN_PATTERN_BYTES; i++) begin
          if (i / 4 == word_idx) begin
            rd_data[8*(i%4) +: 8] = chars_q[pat_idx][i];
          end
        end
      end
      scan_pkg::pattern_len:  rd_data[4:0] = len_q[pat_idx];
      scan_pkg::status_hits:  rd_data[`SCAN_NUM_PATTERNS-1:0] = hits;
      scan_pkg::status_count: rd_data[`SCAN_COUNT_WIDTH-1:0] = hit_count;
      default:                rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req_fire && !wb_req.we) begin
      rd_data_q <= rd_data;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rd_data_q;

  always_comb begin
    for (int p = 0; p < `SCAN_NUM_PATTERNS; p++) begin
      patterns[p].chars = chars_q[p];
      patterns[p].len   = len_q[p];
    end
  end

endmodule

// File: hw/string_comparator.sv
// ----------------------------------------------------------
// String comparator
// Matches one flagged string against a 20-byte window
// at each of the four byte positions of the newest word
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "scan_settings.svh"

module string_comparator (
  input  logic               clk,
  input  logic               n_rst,
  input  logic               clear,
  input  scan_pkg::stream_t  stream,
  input  scan_pkg::pattern_t pattern,
  output logic               hit
);

  // Byte 0 is the latest stream byte, higher indices are older
  logic [`SCAN_WINDOW_BYTES-1:0][7:0] win_q;
  logic                               shifted_q;
  logic [4:0]                         len_eff;
  logic                               align_ok;
  logic                               match;

  // Anything longer than the storage behaves as a full pattern
  assign len_eff = (pattern.len > 5'(`SCAN_PATTERN_BYTES)) ?
                   5'(`SCAN_PATTERN_BYTES) : pattern.len;

  // Alignment a puts the last character on window byte a
  always_comb begin
    match    = 1'b0;
    align_ok = 1'b1;
    for (int a = 0; a < 4; a++) begin
      align_ok = 1'b1;
      for (int j = 0; j < `SCAN_PATTERN_BYTES; j++) begin
        if (j >= `SCAN_PATTERN_BYTES - len_eff &&
            pattern.chars[j] != win_q[a + `SCAN_PATTERN_BYTES - 1 - j]) begin
          align_ok = 1'b0;
        end
      end
      match = match | align_ok;
    end
    // Length 0 disables the pattern
    match = match && (len_eff != 5'd0);
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      win_q     <= '0;
      shifted_q <= 1'b0;
      hit       <= 1'b0;
    end else if (clear) begin
      win_q     <= '0;
      shifted_q <= 1'b0;
      hit       <= 1'b0;
    end else begin
      if (stream.valid) begin
        // Newest word enters at the bottom with its last byte at 0
        win_q <= {win_q[`SCAN_WINDOW_BYTES-5:0],
                  stream.data[7:0], stream.data[15:8],
                  stream.data[23:16], stream.data[31:24]};
      end
      shifted_q <= stream.valid;
      // Result only counts for a cycle that followed a shift
      hit       <= shifted_q && match;
    end
  end

endmodule

// File: hw/match_collector.sv
// ----------------------------------------------------------
// Match collector
// Sticky per-pattern hits, alert and saturating hit counter
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "scan_settings.svh"

module match_collector (
  input  logic                          clk,
  input  logic                          n_rst,
  input  logic                          clear,
  input  logic [`SCAN_NUM_PATTERNS-1:0] word_hits,
  output logic [`SCAN_NUM_PATTERNS-1:0] hits,
  output logic                          alert,
  output logic [`SCAN_COUNT_WIDTH-1:0]  hit_count
);

  logic any_hit;
  logic count_full;

  assign any_hit    = |word_hits;
  assign count_full = &hit_count;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      hits <= '0;
    end else if (clear) begin
      hits <= '0;
    end else begin
      hits <= hits | word_hits;
    end
  end

  // One count per word with any hit, stops at all ones
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      hit_count <= '0;
    end else if (clear) begin
      hit_count <= '0;
    end else if (any_hit && !count_full) begin
      hit_count <= hit_count + 1'b1;
    end
  end

  // Follows the sticky vector directly
  assign alert = |hits;

endmodule

// File: hw/string_scan_top.sv
// ----------------------------------------------------------
// Stream scanner top
// Register block, four string comparators and the collector
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "scan_settings.svh"

module string_scan_top (
  input  logic                          clk,
  input  logic                          n_rst,
  input  scan_pkg::wb_req_t             wb_req,
  output scan_pkg::wb_rsp_t             wb_rsp,
  input  scan_pkg::stream_t             stream,
  output logic [`SCAN_NUM_PATTERNS-1:0] hits,
  output logic                          alert,
  output logic [`SCAN_COUNT_WIDTH-1:0]  hit_count
);

  scan_pkg::pattern_t            patterns [`SCAN_NUM_PATTERNS];
  logic                          clear;
  logic [`SCAN_NUM_PATTERNS-1:0] word_hits;

  pattern_regs u_regs (
    .clk       (clk),
    .n_rst     (n_rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .patterns  (patterns),
    .clear     (clear),
    .hits      (hits),
    .hit_count (hit_count)
  );

  // One comparator per programmable string
  for (genvar p = 0; p < `SCAN_NUM_PATTERNS; p++) begin : g_cmp
    string_comparator u_cmp (
      .clk     (clk),
      .n_rst   (n_rst),
      .clear   (clear),
      .stream  (stream),
      .pattern (patterns[p]),
      .hit     (word_hits[p])
    );
  end

  match_collector u_collect (
    .clk       (clk),
    .n_rst     (n_rst),
    .clear     (clear),
    .word_hits (word_hits),
    .hits      (hits),
    .alert     (alert),
    .hit_count (hit_count)
  );

endmodule

// File: verification/scan_properties.sv
// ----------------------------------------------------------
// Stream scanner assertions
// Bus handshake and sticky hit behaviour, bound to the top
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "scan_settings.svh"

module scan_properties (
  input logic                          clk,
  input logic                          n_rst,
  input scan_pkg::wb_req_t             wb_req,
  input scan_pkg::wb_rsp_t             wb_rsp,
  input logic                          clear,
  input logic [`SCAN_NUM_PATTERNS-1:0] hits,
  input logic                          alert
);

  // Single cycle ack
  assert property (@(posedge clk) disable iff (!n_rst) wb_rsp.ack |=> !wb_rsp.ack)
    else $error("ack held high for two cycles");

  assert property (@(posedge clk) disable iff (!n_rst)
                   wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else $error("ack without a request in the previous cycle");

  // Sticky bits only drop after a clear pulse
  assert property (@(posedge clk) disable iff (!n_rst)
                   (($past(hits) & ~hits) != '0) |-> $past(clear))
    else $error("hit bit fell without a clear");

  assert property (@(posedge clk) disable iff (!n_rst) alert == |hits)
    else $error("alert differs from the OR of the hit bits");

endmodule

bind string_scan_top scan_properties u_props (
  .clk    (clk),
  .n_rst  (n_rst),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp),
  .clear  (clear),
  .hits   (hits),
  .alert  (alert)
);

// File: verification/scan_tb.sv
// ----------------------------------------------------------
// Stream scanner testbench
// Seeded random stream and bus traffic against a byte model
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "scan_settings.svh"

module scan_tb;

  localparam int rounds = 200;
  // Bus setup and clear phases, then at most 25 cycles per stream round
  localparam int max_cycles = 1000 + rounds * 25;

  logic                          clk;
  logic                          n_rst;
  scan_pkg::wb_req_t             wb_req;
  scan_pkg::wb_rsp_t             wb_rsp;
  scan_pkg::stream_t             stream;
  logic [`SCAN_NUM_PATTERNS-1:0] hits;
  logic                          alert;
  logic [`SCAN_COUNT_WIDTH-1:0]  hit_count;

  integer                        seed;
  int                            cycles = 0;
  logic [31:0]                   rdata;
  logic [7:0]                    pat_chars [`SCAN_NUM_PATTERNS][`SCAN_PATTERN_BYTES];
  int                            pat_len [`SCAN_NUM_PATTERNS];
  logic [7:0]                    history [$];
  logic [7:0]                    pending [$];
  logic [`SCAN_NUM_PATTERNS-1:0] exp_hits;
  int                            exp_count;
  // Expected port values, three cycles behind the driven word
  logic [`SCAN_NUM_PATTERNS-1:0] hits_pipe [$];
  int                            count_pipe [$];
  int                            unmapped_adr [6] = '{6, 7, 14, 35, 40, 63};

  string_scan_top u_dut (
    .clk       (clk),
    .n_rst     (n_rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .stream    (stream),
    .hits      (hits),
    .alert     (alert),
    .hit_count (hit_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("TB FAILED");
      $fatal(1, "Run timed out after %0d cycles", cycles);
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
      $display("TB FAILED");
      $fatal(1, "Check on %s failed", name);
    end
  endtask

  // Nonzero bytes only, unfilled window bytes read as zero
  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return 8'd1 + 8'(r[7:0] % 8'd255);
  endfunction

  // Called just after a rising edge, returns one cycle after ack
  task automatic bus_access(input logic we, input int adr, input logic [31:0] wdata,
                            output logic [31:0] rd);
    wb_req = {1'b1, 1'b1, we, adr[`SCAN_ADR_WIDTH-1:0], wdata};
    do begin
      @(posedge clk);
      #1;
    end while (!wb_rsp.ack);
    rd = wb_rsp.dat;
    wb_req = '0;
    @(posedge clk);
    #1;
  endtask

  task automatic read_check(input int adr, input logic [31:0] want, input string name);
    logic [31:0] rd;
    bus_access(1'b0, adr, 32'h0, rd);
    check(name, rd, want);
  endtask

  task automatic program_pattern(input int p, input int len);
    logic [31:0] word;
    logic [31:0] junk;
    for (int k = 0; k < 5; k++) begin
      word = '0;
      for (int b = 0; b < 4 && 4 * k + b < `SCAN_PATTERN_BYTES; b++) begin
        pat_chars[p][4*k+b] = rand_byte();
        word[8*b +: 8] = pat_chars[p][4*k+b];
      end
      bus_access(1'b1, 8 * p + k, word, rdata);
      read_check(8 * p + k, word, "pattern_chars");
    end
    // Upper bits are not stored
    junk = $random(seed);
    pat_len[p] = len;
    bus_access(1'b1, 8 * p + 5, (junk & 32'hffff_ffe0) | len, rdata);
    read_check(8 * p + 5, len, "pattern_len");
  endtask

  // Stream ends with the pattern at one of the word's four byte positions
  task automatic model_word(input logic [31:0] data);
    int last;
    int idx;
    bit ok;
    bit any;
    any = 1'b0;
    for (int b = 0; b < 4; b++) begin
      history.push_back(data[8*b +: 8]);
    end
    for (int p = 0; p < `SCAN_NUM_PATTERNS; p++) begin
      for (int pos = 0; pos < 4; pos++) begin
        last = history.size() - 4 + pos;
        ok = (pat_len[p] > 0);
        for (int j = 0; j < pat_len[p]; j++) begin
          idx = last - pat_len[p] + 1 + j;
          if (idx < 0) begin
            ok = 1'b0;
          end else if (history[idx] != pat_chars[p][`SCAN_PATTERN_BYTES-pat_len[p]+j]) begin
            ok = 1'b0;
          end
        end
        if (ok) begin
          exp_hits[p] = 1'b1;
          any = 1'b1;
        end
      end
    end
    if (any) exp_count++;
  endtask

  task automatic stream_cycle(input logic valid, input logic [31:0] data);
    logic [`SCAN_NUM_PATTERNS-1:0] hp;
    if (hits_pipe.size() == 3) begin
      hp = hits_pipe.pop_front();
      check("hits", hits, hp);
      check("alert", alert, |hp);
      check("hit_count", hit_count, count_pipe.pop_front());
    end
    stream = {valid, data};
    if (valid) model_word(data);
    hits_pipe.push_back(exp_hits);
    count_pipe.push_back(exp_count);
    @(posedge clk);
    #1;
  endtask

  task automatic flush_stream();
    for (int i = 0; i < 3; i++) begin
      stream_cycle(1'b0, 32'h0);
    end
    hits_pipe.delete();
    count_pipe.delete();
    check("hits", hits, exp_hits);
    check("hit_count", hit_count, exp_count);
  endtask

  // Pads to a word boundary, optional idle cycles carry random data
  task automatic send_pending(input bit gaps);
    logic [31:0] word;
    while (pending.size() % 4 != 0) pending.push_back(rand_byte());
    while (pending.size() > 0) begin
      for (int b = 0; b < 4; b++) begin
        word[8*b +: 8] = pending.pop_front();
      end
      while (gaps && ($random(seed) & 3) == 0) stream_cycle(1'b0, $random(seed));
      stream_cycle(1'b1, word);
    end
  endtask

  task automatic feed_random(input int n);
    for (int i = 0; i < n; i++) begin
      pending.push_back(rand_byte());
    end
  endtask

  task automatic feed_bytes(input int p, input int first, input int last);
    for (int j = first; j <= last; j++) begin
      pending.push_back(pat_chars[p][j]);
    end
  endtask

  initial begin
    seed = 32'h23c5_694d;
    wb_req = '0;
    stream = '0;
    n_rst = 1'b0;
    exp_hits = '0;
    exp_count = 0;
    repeat (8) @(posedge clk);
    #1;
    n_rst = 1'b1;
    @(posedge clk);
    #1;
    check("alert", alert, 0);
    read_check(33, 0, "status_hits");
    read_check(34, 0, "status_count");
    program_pattern(0, 17);
    program_pattern(1, 1);
    program_pattern(2, 2 + {$random(seed)} % 15);
    program_pattern(3, 2 + {$random(seed)} % 15);
    foreach (unmapped_adr[i]) read_check(unmapped_adr[i], 0, "unmapped");

    // Random words with inserted patterns, idle gaps in the second half
    for (int r = 0; r < rounds; r++) begin
      feed_random({$random(seed)} % 12);
      begin
        int p;
        p = {$random(seed)} % 4;
        feed_bytes(p, `SCAN_PATTERN_BYTES - pat_len[p], `SCAN_PATTERN_BYTES - 1);
      end
      send_pending(r >= rounds / 2);
    end
    flush_stream();
    read_check(33, exp_hits, "status_hits");
    read_check(34, exp_count, "status_count");

    // Pattern 0 split across a clear
    feed_random(3);
    feed_bytes(0, 0, 8);
    send_pending(1'b0);
    flush_stream();
    bus_access(1'b1, 32, 32'h1, rdata);
    history.delete();
    exp_hits = '0;
    exp_count = 0;
    check("hits", hits, 0);
    check("alert", alert, 0);
    check("hit_count", hit_count, 0);
    read_check(33, 0, "status_hits");
    feed_bytes(0, 9, `SCAN_PATTERN_BYTES - 1);
    send_pending(1'b0);
    flush_stream();
    check("hits[0]", hits[0], 0);

    // Length 0 disables pattern 3 although its bytes still arrive
    bus_access(1'b1, 29, 32'h0, rdata);
    pat_len[3] = 0;
    feed_bytes(3, 0, `SCAN_PATTERN_BYTES - 1);
    send_pending(1'b1);
    flush_stream();
    check("hits[3]", hits[3], 0);
    read_check(34, exp_count, "status_count");

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: all.f
+incdir+hw
hw/scan_pkg.sv
hw/pattern_regs.sv
hw/string_comparator.sv
hw/match_collector.sv
hw/string_scan_top.sv
verification/scan_properties.sv
verification/scan_tb.sv
